// ==== rtl/hio_pkg.sv ====
// host I/O bridge shared definitions
// command opcodes of the host port
// word, byte and counter widths

package hio_pkg;

	// width of the saturating word index
	localparam int WORD_CNT_BITS = 10;

	// has_data flag plus one received byte
	localparam int PS2_RDATA_BITS = 9;

	// one word of the command port
	typedef logic [15:0] io_word_t;

	// one byte on a PS/2 link
	typedef logic [7:0] ps2_byte_t;

	// command codes, taken from the first word after enable
	typedef enum logic [7:0] {
		CMD_CFG      = 8'h01,
		CMD_JOY0     = 8'h02,
		CMD_JOY1     = 8'h03,
		CMD_MOUSE_IN = 8'h04,
		CMD_KBD_IN   = 8'h05,
		CMD_CONF_STR = 8'h14,
		CMD_STATUS   = 8'h1E,
		CMD_PS2_READ = 8'h21,
		CMD_VID_RES  = 8'h23,
		CMD_DMA_WR   = 8'h61
	} hio_cmd_e;

endpackage

// ==== rtl/ps2_host_if.sv ====
// link between the command decoder and one PS/2 device
// host side pushes bytes and acknowledges reads
// device side returns the received byte with its flag

`timescale 1ns/1ps

interface ps2_host_if import hio_pkg::*; ();

	ps2_byte_t                 wdata;
	logic                      we;
	logic [PS2_RDATA_BITS-1:0] rdata;
	logic                      rd;

	// decoder end
	modport host (output wdata, output we, output rd, input rdata);

	// device end
	modport dev (input wdata, input we, input rd, output rdata);

endinterface

// ==== rtl/vid_meas_if.sv ====
// video measurement results
// driven by the timing meter, read by the command decoder

`timescale 1ns/1ps

interface vid_meas_if ();

	// resolution change counter
	logic [7:0]  nres;
	// active pixels per line
	logic [15:0] hact;
	// active lines per frame
	logic [15:0] vact;
	// clk_100 cycles per frame
	logic [31:0] vtime;

	modport meter (output nres, output hact, output vact, output vtime);

	modport reader (input nres, input hact, input vact, input vtime);

endinterface

// ==== rtl/ps2_clk_gen.sv ====
// slow PS/2 clock level generator
// toggles once every ps2_div cycles of clk_100

`timescale 1ns/1ps

module ps2_clk_gen #(
	parameter int ps2_div = 2000
) (
	input  logic clk_100,
	input  logic rst,
	output logic ps2_clk
);

	localparam int CNT_W = $clog2(ps2_div + 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk_100) begin
		if (rst) begin
			cnt     <= '0;
			ps2_clk <= 1'b0;
		end else if (cnt == CNT_W'(ps2_div - 1)) begin
			cnt     <= '0;
			ps2_clk <= ~ps2_clk;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

endmodule

// ==== rtl/ps2_device.sv ====
// PS/2 device emulator
// byte FIFO fed by the host port, oldest entry dropped when full
// device-to-host serializer with odd parity
// host-to-device receiver with acknowledge

`timescale 1ns/1ps

module ps2_device import hio_pkg::*; #(
	parameter int fifo_bits = 4
) (
	input  logic         clk_100,
	input  logic         rst,
	input  logic         ps2_clk,
	ps2_host_if.dev      host,
	output logic         clk_out,
	output logic         dat_out,
	input  logic         clk_in,
	input  logic         dat_in
);

	typedef enum logic [2:0] {TX_IDLE, TX_START, TX_DATA, TX_PARITY, TX_STOP} tx_state_e;
	typedef enum logic [2:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP, RX_ACK} rx_state_e;

	ps2_byte_t            fifo_mem [2**fifo_bits];
	logic [fifo_bits:0]   wptr;
	logic [fifo_bits:0]   rptr;

	tx_state_e tx_state;
	rx_state_e rx_state;
	ps2_byte_t tx_byte;
	logic      parity;
	logic [2:0] tx_left;
	logic [1:0] idle_cnt;
	ps2_byte_t rx_byte;
	logic [3:0] rx_cnt;
	logic      has_data;

	logic       old_clk;
	logic [1:0] clk_s;
	logic       dat_s;

	// extra pointer bit tells full from empty
	wire fifo_empty = (wptr == rptr);
	wire fifo_full  = (wptr[fifo_bits] != rptr[fifo_bits]) &&
		(wptr[fifo_bits-1:0] == rptr[fifo_bits-1:0]);

	wire ps2_rise  = ps2_clk & ~old_clk;
	wire ps2_fall  = ~ps2_clk & old_clk;
	wire line_idle = clk_s[1] & dat_s;
	wire rx_begin  = clk_s[0] & ~clk_s[1] & ~dat_s;
	wire link_busy = (tx_state != TX_IDLE) || (rx_state != RX_IDLE && rx_state != RX_START);
	wire tx_pop    = ps2_rise && rx_state == RX_IDLE && tx_state == TX_IDLE &&
		line_idle && idle_cnt == 2'd3 && !fifo_empty;

	assign host.rdata = {has_data, rx_byte};

	always_ff @(posedge clk_100) begin
		if (host.we)
			fifo_mem[wptr[fifo_bits-1:0]] <= host.wdata;
	end

	always_ff @(posedge clk_100) begin
		if (rst) begin
			wptr     <= '0;
			rptr     <= '0;
			tx_state <= TX_IDLE;
			rx_state <= RX_IDLE;
			idle_cnt <= '0;
			has_data <= 1'b0;
			clk_out  <= 1'b1;
			dat_out  <= 1'b1;
			old_clk  <= 1'b0;
			clk_s    <= 2'b11;
			dat_s    <= 1'b1;
		end else begin
			old_clk <= ps2_clk;
			clk_s   <= {clk_s[0], clk_in};
			dat_s   <= dat_in;

			if (host.we)
				wptr <= wptr + 1'b1;
			// a push into a full FIFO discards the oldest byte
			if (tx_pop || (host.we && fifo_full))
				rptr <= rptr + 1'b1;

			if (host.rd)
				has_data <= 1'b0;

			// host pulled data low and released clock
			if (rx_state == RX_IDLE && tx_state == TX_IDLE && rx_begin) begin
				rx_state <= RX_START;
				dat_out  <= 1'b1;
			end

			if (ps2_rise) begin
				clk_out <= 1'b1;
				if (rx_state != RX_IDLE) begin
					idle_cnt <= '0;
					case (rx_state)
						RX_START: begin
							rx_cnt   <= '0;
							rx_state <= RX_DATA;
						end
						RX_DATA: begin
							// eight data bits, LSB first, then skip parity
							if (rx_cnt <= 4'd7)
								rx_byte <= {dat_s, rx_byte[7:1]};
							else
								rx_state <= RX_STOP;
							rx_cnt <= rx_cnt + 1'b1;
						end
						RX_STOP: begin
							if (dat_s) begin
								dat_out  <= 1'b0;
								rx_state <= RX_ACK;
							end
						end
						default: begin
							dat_out  <= 1'b1;
							has_data <= 1'b1;
							rx_state <= RX_IDLE;
						end
					endcase
				end else begin
					case (tx_state)
						TX_IDLE: begin
							if (!line_idle)
								idle_cnt <= '0;
							else if (idle_cnt != 2'd3)
								idle_cnt <= idle_cnt + 1'b1;
							else if (!fifo_empty) begin
								tx_byte  <= fifo_mem[rptr[fifo_bits-1:0]];
								parity   <= ~^fifo_mem[rptr[fifo_bits-1:0]];
								dat_out  <= 1'b0;
								idle_cnt <= '0;
								tx_state <= TX_START;
							end
						end
						TX_START: begin
							dat_out  <= tx_byte[0];
							tx_byte  <= tx_byte >> 1;
							tx_left  <= 3'd7;
							tx_state <= TX_DATA;
						end
						TX_DATA: begin
							if (tx_left == 3'd0) begin
								dat_out  <= parity;
								tx_state <= TX_PARITY;
							end else begin
								dat_out <= tx_byte[0];
								tx_byte <= tx_byte >> 1;
								tx_left <= tx_left - 1'b1;
							end
						end
						TX_PARITY: begin
							// stop bit
							dat_out  <= 1'b1;
							tx_state <= TX_STOP;
						end
						default: tx_state <= TX_IDLE;
					endcase
				end
			end

			if (ps2_fall)
				clk_out <= !link_busy;
		end
	end

endmodule

// ==== rtl/vid_timing_meter.sv ====
// video timing meter on clk_100
// active width of the first active line, active lines per frame
// frame period in cycles, resolution change counter

`timescale 1ns/1ps

module vid_timing_meter (
	input  logic      clk_100,
	input  logic      rst,
	input  logic      de,
	input  logic      hs,
	input  logic      vs,
	input  logic      new_vmode,
	vid_meas_if.meter meas
);

	// {new_vmode, vs, hs, de}
	logic [3:0]  s1, s2, s3;
	logic [15:0] hcnt, vcnt;
	logic [31:0] vtime_cnt;
	logic        calch;
	logic        old_vmode;

	wire de_s    = s2[0];
	wire de_rise = s2[0] & ~s3[0];
	wire hs_rise = s2[1] & ~s3[1];
	wire vs_s    = s2[2];
	wire vs_rise = s2[2] & ~s3[2];
	wire vs_fall = ~s2[2] & s3[2];
	wire vmode_s = s2[3];

	always_ff @(posedge clk_100) begin
		if (rst) begin
			{s1, s2, s3} <= '0;
			{hcnt, vcnt} <= '0;
			vtime_cnt    <= '0;
			calch        <= 1'b0;
			old_vmode    <= 1'b0;
			meas.nres    <= '0;
			meas.hact    <= '0;
			meas.vact    <= '0;
			meas.vtime   <= '0;
		end else begin
			s1 <= {new_vmode, vs, hs, de};
			s2 <= s1;
			s3 <= s2;

			// frame period, edge to edge
			vtime_cnt <= vtime_cnt + 1'b1;
			if (vs_rise) begin
				meas.vtime <= vtime_cnt;
				vtime_cnt  <= 32'd1;
			end

			if (~vs_s & de_rise)
				vcnt <= vcnt + 1'b1;
			if (calch & de_s)
				hcnt <= hcnt + 1'b1;
			// window closes at the end of the first active line
			if (calch & hs_rise & (hcnt != '0))
				calch <= 1'b0;

			if (vs_fall) begin
				if (hcnt != '0 && vcnt != '0) begin
					old_vmode <= vmode_s;
					if (meas.hact != hcnt || meas.vact != vcnt || old_vmode != vmode_s)
						meas.nres <= meas.nres + 1'b1;
					meas.hact <= hcnt;
					meas.vact <= vcnt;
				end
				hcnt  <= '0;
				vcnt  <= '0;
				calch <= 1'b1;
			end
		end
	end

endmodule

// ==== rtl/hio_cmd_decoder.sv ====
// host command port decoder
// word index, latched opcode and DMA half-word phase
// configuration, joystick and status registers
// registered replies for string, PS/2 and video queries

`timescale 1ns/1ps

module hio_cmd_decoder import hio_pkg::*; #(
	parameter int conf_len = 8
) (
	input  logic                  clk_100,
	input  logic                  rst,
	input  logic                  io_enable,
	input  logic                  io_strobe,
	input  io_word_t              io_din,
	output io_word_t              io_dout,
	input  logic [8*conf_len-1:0] conf_str,
	output logic [1:0]            buttons,
	output logic [15:0]           joystick_0,
	output logic [15:0]           joystick_1,
	output logic [31:0]           status,
	output logic [31:0]           dma_addr,
	output logic [31:0]           dma_dout,
	output logic                  dma_wr,
	ps2_host_if.host              kbd,
	ps2_host_if.host              mouse,
	vid_meas_if.reader            meas
);

	logic [WORD_CNT_BITS-1:0] wcnt;
	hio_cmd_e                 cmd;
	logic                     dma_hilo;
	logic [7:0]               cfg;
	logic [7:0]               conf_byte;

	// operand word accepted this cycle
	wire opnd = io_enable & io_strobe & (wcnt != '0);

	assign buttons = cfg[1:0];

	// byte 1 sits in the top eight bits of the string
	always_comb begin
		conf_byte = '0;
		for (int i = 1; i <= conf_len; i++) begin
			if (wcnt == WORD_CNT_BITS'(i))
				conf_byte = conf_str[(conf_len - i)*8 +: 8];
		end
	end

	////////////////////////////////////////////////////////////
	// control state and replies
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_100) begin
		if (rst) begin
			wcnt       <= '0;
			cmd        <= CMD_CFG;
			dma_hilo   <= 1'b0;
			io_dout    <= '0;
			dma_wr     <= 1'b0;
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			kbd.we     <= 1'b0;
			kbd.rd     <= 1'b0;
			mouse.we   <= 1'b0;
			mouse.rd   <= 1'b0;
		end else begin
			dma_wr   <= 1'b0;
			kbd.we   <= 1'b0;
			kbd.rd   <= 1'b0;
			mouse.we <= 1'b0;
			mouse.rd <= 1'b0;

			if (!io_enable) begin
				wcnt     <= '0;
				io_dout  <= '0;
				dma_hilo <= 1'b0;
			end else if (io_strobe) begin
				io_dout <= '0;
				if (wcnt != '1)
					wcnt <= wcnt + 1'b1;

				if (wcnt == '0) begin
					cmd      <= hio_cmd_e'(io_din[7:0]);
					dma_hilo <= 1'b0;
				end else begin
					case (cmd)
						CMD_CFG:  if (wcnt == 'd1) cfg <= io_din[7:0];
						CMD_JOY0: if (wcnt == 'd1) joystick_0 <= io_din;
						CMD_JOY1: if (wcnt == 'd1) joystick_1 <= io_din;
						CMD_STATUS: begin
							if (wcnt == 'd1)
								status[15:0] <= io_din;
							else if (wcnt == 'd2)
								status[31:16] <= io_din;
						end
						CMD_MOUSE_IN: mouse.we <= 1'b1;
						CMD_KBD_IN:   kbd.we <= 1'b1;
						CMD_CONF_STR: io_dout <= io_word_t'(conf_byte);
						CMD_PS2_READ: begin
							if (wcnt == 'd1) begin
								io_dout <= io_word_t'(kbd.rdata);
								kbd.rd  <= 1'b1;
							end else if (wcnt == 'd2) begin
								io_dout  <= io_word_t'(mouse.rdata);
								mouse.rd <= 1'b1;
							end
						end
						CMD_VID_RES: begin
							case (wcnt)
								'd1: io_dout <= io_word_t'(meas.nres);
								'd2: io_dout <= meas.hact;
								'd3: io_dout <= meas.vact;
								'd4: io_dout <= meas.vtime[15:0];
								'd5: io_dout <= meas.vtime[31:16];
								default: io_dout <= '0;
							endcase
						end
						CMD_DMA_WR: begin
							// data words alternate low and high halves
							if (wcnt > 'd2) begin
								if (dma_hilo)
									dma_wr <= 1'b1;
								dma_hilo <= ~dma_hilo;
							end
						end
						default: io_dout <= '0;
					endcase
				end
			end
		end
	end

	////////////////////////////////////////////////////////////
	// payload registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_100) begin
		if (opnd) begin
			case (cmd)
				CMD_MOUSE_IN: mouse.wdata <= io_din[7:0];
				CMD_KBD_IN:   kbd.wdata <= io_din[7:0];
				CMD_DMA_WR: begin
					if (wcnt == 'd1)
						dma_addr[15:0] <= io_din;
					else if (wcnt == 'd2)
						dma_addr[31:16] <= io_din;
					else if (!dma_hilo) begin
						// next address from the second pair on
						if (wcnt > 'd4)
							dma_addr <= dma_addr + 32'd4;
						dma_dout[15:0] <= io_din;
					end else begin
						dma_dout[31:16] <= io_din;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== rtl/hio_top.sv ====
// host I/O bridge top level
// command decoder, shared PS/2 clock, keyboard and mouse devices
// video timing meter

`timescale 1ns/1ps

module hio_top import hio_pkg::*; #(
	parameter int conf_len  = 8,
	parameter int ps2_div   = 2000,
	parameter int fifo_bits = 4
) (
	input  logic                  clk_100,
	input  logic                  rst,
	input  logic                  io_enable,
	input  logic                  io_strobe,
	input  io_word_t              io_din,
	output io_word_t              io_dout,
	input  logic [8*conf_len-1:0] conf_str,
	output logic [1:0]            buttons,
	output logic [15:0]           joystick_0,
	output logic [15:0]           joystick_1,
	output logic [31:0]           status,
	output logic [31:0]           dma_addr,
	output logic [31:0]           dma_dout,
	output logic                  dma_wr,
	input  logic                  new_vmode,
	input  logic                  vid_de,
	input  logic                  vid_hs,
	input  logic                  vid_vs,
	output logic                  kbd_clk_out,
	output logic                  kbd_dat_out,
	input  logic                  kbd_clk_in,
	input  logic                  kbd_dat_in,
	output logic                  mouse_clk_out,
	output logic                  mouse_dat_out,
	input  logic                  mouse_clk_in,
	input  logic                  mouse_dat_in
);

	logic ps2_clk;

	ps2_host_if kbd_if ();
	ps2_host_if mouse_if ();
	vid_meas_if meas_if ();

	hio_cmd_decoder #(.conf_len(conf_len)) u_decoder (
		.clk_100(clk_100), .rst(rst),
		.io_enable(io_enable), .io_strobe(io_strobe),
		.io_din(io_din), .io_dout(io_dout),
		.conf_str(conf_str), .buttons(buttons),
		.joystick_0(joystick_0), .joystick_1(joystick_1),
		.status(status),
		.dma_addr(dma_addr), .dma_dout(dma_dout), .dma_wr(dma_wr),
		.kbd(kbd_if.host), .mouse(mouse_if.host), .meas(meas_if.reader)
	);

	// one slow clock shared by both devices
	ps2_clk_gen #(.ps2_div(ps2_div)) u_ps2_clk (
		.clk_100(clk_100), .rst(rst), .ps2_clk(ps2_clk)
	);

	ps2_device #(.fifo_bits(fifo_bits)) u_kbd (
		.clk_100(clk_100), .rst(rst), .ps2_clk(ps2_clk), .host(kbd_if.dev),
		.clk_out(kbd_clk_out), .dat_out(kbd_dat_out),
		.clk_in(kbd_clk_in), .dat_in(kbd_dat_in)
	);

	ps2_device #(.fifo_bits(fifo_bits)) u_mouse (
		.clk_100(clk_100), .rst(rst), .ps2_clk(ps2_clk), .host(mouse_if.dev),
		.clk_out(mouse_clk_out), .dat_out(mouse_dat_out),
		.clk_in(mouse_clk_in), .dat_in(mouse_dat_in)
	);

	vid_timing_meter u_meter (
		.clk_100(clk_100), .rst(rst),
		.de(vid_de), .hs(vid_hs), .vs(vid_vs), .new_vmode(new_vmode),
		.meas(meas_if.meter)
	);

endmodule

// ==== verif/hio_assertions.sv ====
// concurrent checks on the command decoder
// single-cycle DMA strobe, reply cleared and no PS/2 pulses while disabled

`timescale 1ns/1ps

module hio_assertions (
	input logic        clk_100,
	input logic        rst,
	input logic        io_enable,
	input logic [15:0] io_dout,
	input logic        dma_wr,
	input logic        kbd_we,
	input logic        kbd_rd,
	input logic        mouse_we,
	input logic        mouse_rd
);

	a_dma_wr_pulse: assert property (@(posedge clk_100) disable iff (rst)
		dma_wr |=> !dma_wr) else $error("dma_wr held for two cycles");

	a_dout_clear: assert property (@(posedge clk_100) disable iff (rst)
		$fell(io_enable) |=> io_dout == '0) else $error("io_dout not cleared");

	a_no_ps2_pulse: assert property (@(posedge clk_100) disable iff (rst)
		!io_enable |=> !(kbd_we || kbd_rd || mouse_we || mouse_rd))
		else $error("PS/2 pulse while the port is disabled");

endmodule

bind hio_cmd_decoder hio_assertions u_assertions (
	.clk_100(clk_100), .rst(rst), .io_enable(io_enable), .io_dout(io_dout),
	.dma_wr(dma_wr), .kbd_we(kbd.we), .kbd_rd(kbd.rd),
	.mouse_we(mouse.we), .mouse_rd(mouse.rd)
);

// ==== verif/hio_tb.sv ====
// testbench for the host I/O bridge
// clock, reset, LFSR stimulus and host-word tasks
// PS/2 frame decoder and host-to-device driver, video frame generator
// reference function and comparisons

`timescale 1ns/1ps

module hio_tb import hio_pkg::*; ();

	localparam int CONF_LEN = 8;
	localparam int PS2_DIV = 4;
	localparam logic [8*CONF_LEN-1:0] CONF_VAL = 64'h48494F4252444731;
	// characters of the configuration string in reading order
	localparam logic [7:0] CONF_CHARS [CONF_LEN] = '{"H", "I", "O", "B", "R", "D", "G", "1"};
	localparam int W1 = 12;
	localparam int W2 = 16;
	localparam int VH = 5;
	// watchdog budget in clock cycles
	localparam int N_WORDS = 80;
	localparam int N_PS2 = 3;
	localparam int N_FRAMES = 8;
	localparam int FRAME_MAX = (VH + 4) * (W2 + 6);
	localparam int LIMIT_CYC = 2 * (N_WORDS * 2 + N_PS2 * 16 * 2 * PS2_DIV
		+ N_FRAMES * FRAME_MAX + 200);

	logic clk_100, rst, io_enable, io_strobe;
	io_word_t io_din, io_dout;
	logic [8*CONF_LEN-1:0] conf_str;
	logic [1:0] buttons;
	logic [15:0] joystick_0, joystick_1;
	logic [31:0] status, dma_addr, dma_dout;
	logic dma_wr, new_vmode, vid_de, vid_hs, vid_vs;
	logic kbd_clk_out, kbd_dat_out, kbd_clk_in, kbd_dat_in;
	logic mouse_clk_out, mouse_dat_out, mouse_clk_in, mouse_dat_in;

	logic [31:0] lfsr;
	int errors;
	int failures;
	logic [31:0] dma_addr_q[$];
	logic [31:0] dma_data_q[$];

	hio_top #(.conf_len(CONF_LEN), .ps2_div(PS2_DIV)) DUT (.*);

	initial begin
		clk_100 = 1'b0;
		forever #50 clk_100 = ~clk_100;
	end

	initial begin
		#(LIMIT_CYC * 100);
		$display("timeout: the run did not finish in %0d cycles", LIMIT_CYC);
		$display("Test failed");
		$finish;
	end

	// capture each DMA write away from the clock edge
	always @(negedge clk_100) begin
		if (dma_wr) begin
			dma_addr_q.push_back(dma_addr);
			dma_data_q.push_back(dma_dout);
		end
	end

	// fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] v;
		logic fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v = {v[14:0], fb};
		end
		return v;
	endfunction

	// expected register or reply value for operand idx
	function automatic logic [31:0] hio_expect(input hio_cmd_e cmd, input int idx,
			input logic [15:0] a, input logic [15:0] b);
		case (cmd)
			CMD_CFG: return {30'd0, a[1:0]};
			CMD_JOY0, CMD_JOY1: return {16'd0, a};
			CMD_STATUS: return {b, a};
			CMD_CONF_STR: begin
				if (idx < 1 || idx > CONF_LEN)
					return '0;
				return {24'd0, CONF_CHARS[idx - 1]};
			end
			// idx counts data pairs from 0 and a and b hold the base address halves
			CMD_DMA_WR: return {b, a} + 32'(4 * idx);
			// a holds the active width and b the active height
			CMD_VID_RES: begin
				case (idx)
					2: return {16'd0, a};
					3: return {16'd0, b};
					4: return {16'd0, 16'((b + 4) * (a + 6))};
					5: return 32'((b + 4) * (a + 6)) >> 16;
					default: return '0;
				endcase
			end
			default: return '0;
		endcase
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_fail(input string msg);
		failures++;
		$display("%0t: %s", $time, msg);
	endtask

	task automatic host_word(input io_word_t w, output io_word_t reply);
		@(posedge clk_100);
		#1;
		io_din = w;
		io_strobe = 1'b1;
		@(posedge clk_100);
		#1;
		io_strobe = 1'b0;
		reply = io_dout;
	endtask

	task automatic open_cmd(input hio_cmd_e c);
		io_word_t r;
		@(posedge clk_100);
		#1;
		io_enable = 1'b1;
		host_word(io_word_t'(c), r);
	endtask

	task automatic close_cmd();
		@(posedge clk_100);
		#1;
		io_enable = 1'b0;
		@(posedge clk_100);
		#1;
		compare("io_dout", 32'(io_dout), '0);
	endtask

	// one device-to-host frame sampled on falling clk_out
	task automatic kbd_frame(input ps2_byte_t exp);
		ps2_byte_t data;
		logic start, par, stop;
		@(negedge kbd_clk_out);
		start = kbd_dat_out;
		for (int i = 0; i < 8; i++) begin
			@(negedge kbd_clk_out);
			data[i] = kbd_dat_out;
		end
		@(negedge kbd_clk_out);
		par = kbd_dat_out;
		@(negedge kbd_clk_out);
		stop = kbd_dat_out;
		if (start !== 1'b0)
			report_fail("keyboard frame start bit was not low");
		compare("kbd byte", 32'(data), 32'(exp));
		compare("kbd parity", 32'(par), 32'(~^exp));
		if (stop !== 1'b1)
			report_fail("keyboard frame stop bit was not high");
	endtask

	// host-to-device frame with bits changing after the device pulls its clock low
	task automatic mouse_send(input ps2_byte_t b);
		logic [9:0] bits;
		bits = {1'b1, ~^b, b};
		@(posedge clk_100);
		#1;
		mouse_dat_in = 1'b0;
		mouse_clk_in = 1'b0;
		repeat (3) @(posedge clk_100);
		#1;
		mouse_clk_in = 1'b1;
		for (int i = 0; i < 10; i++) begin
			@(negedge mouse_clk_out);
			@(posedge clk_100);
			#1;
			mouse_dat_in = bits[i];
		end
		@(negedge mouse_dat_out);
		@(posedge mouse_dat_out);
	endtask

	task automatic video_frame(input int w, input int h);
		for (int ln = 0; ln < h + 4; ln++) begin
			for (int px = 0; px < w + 6; px++) begin
				@(posedge clk_100);
				#1;
				vid_vs = (ln < 2);
				vid_de = (ln >= 3) && (ln < 3 + h) && (px < w);
				vid_hs = (px >= w + 2) && (px < w + 4);
			end
		end
	endtask

	task automatic check_video(input int w, input int h, output logic [15:0] nres);
		io_word_t r;
		open_cmd(CMD_VID_RES);
		host_word('0, r);
		nres = r;
		for (int i = 2; i <= 5; i++) begin
			host_word('0, r);
			compare($sformatf("vid_res word %0d", i), 32'(r),
				hio_expect(CMD_VID_RES, i, 16'(w), 16'(h)));
		end
		close_cmd();
	endtask

	initial begin
		io_word_t r, a, b;
		io_word_t dlo[3], dhi[3];
		ps2_byte_t kb[2], mb;
		logic [15:0] nres0, nres1;

		lfsr = 32'h92a6610b;
		errors = 0;
		failures = 0;
		rst = 1'b1;
		{io_enable, io_strobe, io_din} = '0;
		conf_str = CONF_VAL;
		{new_vmode, vid_de, vid_hs, vid_vs} = '0;
		{kbd_clk_in, kbd_dat_in, mouse_clk_in, mouse_dat_in} = 4'b1111;
		repeat (2) @(posedge clk_100);
		#1;
		rst = 1'b0;

		////////////////////////////////////////////////////////////
		// register writes
		a = rand_bits(16);
		open_cmd(CMD_CFG);
		host_word(a, r);
		close_cmd();
		compare("buttons", 32'(buttons), hio_expect(CMD_CFG, 1, a, 0));
		a = rand_bits(16);
		open_cmd(CMD_JOY0);
		host_word(a, r);
		close_cmd();
		compare("joystick_0", 32'(joystick_0), hio_expect(CMD_JOY0, 1, a, 0));
		a = rand_bits(16);
		open_cmd(CMD_JOY1);
		host_word(a, r);
		close_cmd();
		compare("joystick_1", 32'(joystick_1), hio_expect(CMD_JOY1, 1, a, 0));
		a = rand_bits(16);
		b = rand_bits(16);
		open_cmd(CMD_STATUS);
		host_word(a, r);
		host_word(b, r);
		close_cmd();
		compare("status", status, hio_expect(CMD_STATUS, 2, a, b));

		// configuration string readback
		open_cmd(CMD_CONF_STR);
		for (int n = 1; n <= CONF_LEN + 2; n++) begin
			host_word('0, r);
			compare($sformatf("conf_str byte %0d", n), 32'(r),
				hio_expect(CMD_CONF_STR, n, 0, 0));
		end
		close_cmd();

		////////////////////////////////////////////////////////////
		// DMA stream
		a = rand_bits(16);
		b = rand_bits(16);
		open_cmd(CMD_DMA_WR);
		host_word(a, r);
		host_word(b, r);
		for (int k = 0; k < 3; k++) begin
			dlo[k] = rand_bits(16);
			dhi[k] = rand_bits(16);
			host_word(dlo[k], r);
			host_word(dhi[k], r);
		end
		close_cmd();
		if (dma_addr_q.size() != 3)
			report_fail($sformatf("expected 3 DMA writes, saw %0d", dma_addr_q.size()));
		for (int k = 0; k < 3 && k < dma_addr_q.size(); k++) begin
			compare("dma_addr", dma_addr_q[k], hio_expect(CMD_DMA_WR, k, a, b));
			compare("dma_dout", dma_data_q[k], {dhi[k], dlo[k]});
		end

		////////////////////////////////////////////////////////////
		// keyboard transmit
		kb[0] = ps2_byte_t'(rand_bits(8));
		kb[1] = ps2_byte_t'(rand_bits(8));
		fork
			begin
				open_cmd(CMD_KBD_IN);
				host_word(io_word_t'(kb[0]), r);
				host_word(io_word_t'(kb[1]), r);
				close_cmd();
			end
			begin
				kbd_frame(kb[0]);
				kbd_frame(kb[1]);
			end
		join

		// mouse receive and readback
		mb = ps2_byte_t'(rand_bits(8));
		mouse_send(mb);
		repeat (4) @(posedge clk_100);
		open_cmd(CMD_PS2_READ);
		host_word('0, r);
		host_word('0, r);
		close_cmd();
		compare("mouse rdata", 32'(r), 32'({7'd0, 1'b1, mb}));
		open_cmd(CMD_PS2_READ);
		host_word('0, r);
		host_word('0, r);
		close_cmd();
		if (r[8] !== 1'b0)
			report_fail("mouse has_data still set after it was read");

		////////////////////////////////////////////////////////////
		// video resolution change
		repeat (3) video_frame(W1, VH);
		{vid_de, vid_hs, vid_vs} = '0;
		check_video(W1, VH, nres0);
		repeat (3) video_frame(W2, VH);
		{vid_de, vid_hs, vid_vs} = '0;
		check_video(W2, VH, nres1);
		compare("nres", 32'(nres1), 32'(nres0 + 16'd1));

		$display("errors: %0d mismatches, %0d other failures", errors, failures);
		if (errors == 0 && failures == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== filelist.f ====
rtl/hio_pkg.sv
rtl/ps2_host_if.sv
rtl/vid_meas_if.sv
rtl/ps2_clk_gen.sv
rtl/ps2_device.sv
rtl/vid_timing_meter.sv
rtl/hio_cmd_decoder.sv
rtl/hio_top.sv
verif/hio_assertions.sv
verif/hio_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the host I/O bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module hio_tb -o hio_sim
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/hio_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0
